// File: rv_isa_pkg.sv
//**************************************************
// RV32I encoding definitions
//**************************************************
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] xlen_t;    // data word and address
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // instruction formats
    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE    // unknown opcode, no operands
    } inst_fmt_t;

    // major opcodes
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // load widths
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // store widths
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;  // sub / sra

endpackage

`default_nettype wire

// File: core_pkg.sv
//**************************************************
// Core internal types
//**************************************************
`default_nettype none

package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // fetch sequencer, one instruction per IDLE/WAIT pair
    typedef enum logic {
        IDLE,
        WAIT
    } fetch_state_t;

    typedef struct packed {
        rv_isa_pkg::opcode_t   opcode;
        rv_isa_pkg::funct3_t   funct3;
        rv_isa_pkg::reg_idx_t  rd;
        rv_isa_pkg::reg_idx_t  rs1;
        rv_isa_pkg::reg_idx_t  rs2;
        rv_isa_pkg::xlen_t     imm;     // sign extended per format
        rv_isa_pkg::inst_fmt_t fmt;
        alu_op_t               alu_op;
    } decode_t;

    typedef struct packed {
        rv_isa_pkg::xlen_t alu_result;
        logic              jump_en;
        rv_isa_pkg::xlen_t jump_target;
    } exec_t;

    typedef struct packed {
        rv_isa_pkg::xlen_t addr;
        rv_isa_pkg::xlen_t wdata;
        logic [3:0]        wmask;   // byte lanes from addr
        logic              we;      // one-cycle strobe
    } dmem_req_t;

    typedef struct packed {
        rv_isa_pkg::xlen_t    pc;
        rv_isa_pkg::xlen_t    next_pc;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::xlen_t    wdata;
        logic                 we;
    } retire_t;

endpackage

`default_nettype wire

// File: fetch_unit.sv
//**************************************************
// Fetch unit
//**************************************************
`default_nettype none

module fetch_unit #(
    parameter rv_isa_pkg::xlen_t RESET_PC = 32'h8000_0000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              jump_en,
    input  rv_isa_pkg::xlen_t jump_target,
    output rv_isa_pkg::xlen_t pc,
    output rv_isa_pkg::xlen_t snpc,
    output rv_isa_pkg::xlen_t next_pc,
    output logic              inst_valid
);

    core_pkg::fetch_state_t state;

    assign snpc       = pc + 32'd4;                     // sequential successor
    assign next_pc    = jump_en ? jump_target : snpc;
    assign inst_valid = (state == core_pkg::WAIT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= core_pkg::IDLE;
        end else begin
            case (state)
                core_pkg::IDLE: state <= core_pkg::WAIT;
                default:        state <= core_pkg::IDLE;
            endcase
        end
    end

    // pc advances at the edge that ends WAIT
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (inst_valid) begin
            pc <= next_pc;
        end
    end

    a_idle_to_wait: assert property (@(posedge clk) disable iff (reset)
        (state == core_pkg::IDLE) |=> (state == core_pkg::WAIT));
    a_wait_to_idle: assert property (@(posedge clk) disable iff (reset)
        (state == core_pkg::WAIT) |=> (state == core_pkg::IDLE));

endmodule

`default_nettype wire

// File: decode_unit.sv
//**************************************************
// Instruction decode
//**************************************************
`default_nettype none

module decode_unit (
    input  rv_isa_pkg::xlen_t inst,
    output core_pkg::decode_t dec
);

    rv_isa_pkg::opcode_t   opcode;
    rv_isa_pkg::funct3_t   funct3;
    logic [6:0]            funct7;
    rv_isa_pkg::inst_fmt_t fmt;
    rv_isa_pkg::xlen_t     imm;
    core_pkg::alu_op_t     alu_op;
    logic                  alt;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign alt    = (funct7 == rv_isa_pkg::FUNCT7_ALT);

    always_comb begin
        case (opcode)
            rv_isa_pkg::OP_REG:    fmt = rv_isa_pkg::FMT_R;
            rv_isa_pkg::OP_IMM,
            rv_isa_pkg::OP_LOAD,
            rv_isa_pkg::OP_JALR:   fmt = rv_isa_pkg::FMT_I;
            rv_isa_pkg::OP_STORE:  fmt = rv_isa_pkg::FMT_S;
            rv_isa_pkg::OP_BRANCH: fmt = rv_isa_pkg::FMT_B;
            rv_isa_pkg::OP_LUI,
            rv_isa_pkg::OP_AUIPC:  fmt = rv_isa_pkg::FMT_U;
            rv_isa_pkg::OP_JAL:    fmt = rv_isa_pkg::FMT_J;
            default:               fmt = rv_isa_pkg::FMT_NONE;
        endcase
    end

    always_comb begin
        case (fmt)
            rv_isa_pkg::FMT_I: imm = {{20{inst[31]}}, inst[31:20]};
            rv_isa_pkg::FMT_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_isa_pkg::FMT_B: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_isa_pkg::FMT_U: imm = {inst[31:12], 12'b0};
            rv_isa_pkg::FMT_J: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:           imm = '0;
        endcase
    end

    // only register and immediate arithmetic use funct3, everything else adds
    always_comb begin
        alu_op = core_pkg::ALU_ADD;
        if (opcode == rv_isa_pkg::OP_REG || opcode == rv_isa_pkg::OP_IMM) begin
            case (funct3)
                3'b000: begin
                    if (opcode == rv_isa_pkg::OP_REG && alt) begin
                        alu_op = core_pkg::ALU_SUB;
                    end
                end
                3'b001:  alu_op = core_pkg::ALU_SLL;
                3'b010:  alu_op = core_pkg::ALU_SLT;
                3'b011:  alu_op = core_pkg::ALU_SLTU;
                3'b100:  alu_op = core_pkg::ALU_XOR;
                3'b101:  alu_op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;  // srai shares funct7
                3'b110:  alu_op = core_pkg::ALU_OR;
                default: alu_op = core_pkg::ALU_AND;
            endcase
        end
    end

    assign dec = '{opcode: opcode, funct3: funct3, rd: inst[11:7], rs1: inst[19:15],
                   rs2: inst[24:20], imm: imm, fmt: fmt, alu_op: alu_op};

endmodule

`default_nettype wire

// File: reg_file.sv
//**************************************************
// Integer register file
//**************************************************
`default_nettype none

module reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 we,
    input  logic                 inst_valid,
    input  rv_isa_pkg::reg_idx_t waddr,
    input  rv_isa_pkg::xlen_t    wdata,
    input  rv_isa_pkg::reg_idx_t raddr1,
    input  rv_isa_pkg::reg_idx_t raddr2,
    output rv_isa_pkg::xlen_t    rdata1,
    output rv_isa_pkg::xlen_t    rdata2
);

    rv_isa_pkg::xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && inst_valid && waddr != '0) begin  // x0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    // reads are combinational
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // storage of x0 never picks up a value
    a_x0_zero: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> (regs[0] == '0));

endmodule

`default_nettype wire

// File: execute_unit.sv
//**************************************************
// Execute: ALU and branch resolution
//**************************************************
`default_nettype none

module execute_unit (
    input  core_pkg::decode_t dec,
    input  rv_isa_pkg::xlen_t pc,
    input  rv_isa_pkg::xlen_t rdata1,
    input  rv_isa_pkg::xlen_t rdata2,
    output core_pkg::exec_t   ex
);

    rv_isa_pkg::xlen_t alu_a;
    rv_isa_pkg::xlen_t alu_b;
    rv_isa_pkg::xlen_t alu_result;
    rv_isa_pkg::xlen_t jump_target;
    logic              jump_en;
    logic              taken;

    // operand a by format, operand b is rs2 only for R type
    always_comb begin
        case (dec.fmt)
            rv_isa_pkg::FMT_U: alu_a = (dec.opcode == rv_isa_pkg::OP_LUI) ? '0 : pc;
            rv_isa_pkg::FMT_J,
            rv_isa_pkg::FMT_B: alu_a = pc;
            default:           alu_a = rdata1;
        endcase
        alu_b = (dec.fmt == rv_isa_pkg::FMT_R) ? rdata2 : dec.imm;
    end

    always_comb begin
        case (dec.alu_op)
            core_pkg::ALU_ADD:  alu_result = alu_a + alu_b;
            core_pkg::ALU_SUB:  alu_result = alu_a - alu_b;
            core_pkg::ALU_SLL:  alu_result = alu_a << alu_b[4:0];
            core_pkg::ALU_SLT:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            core_pkg::ALU_SLTU: alu_result = {31'b0, alu_a < alu_b};
            core_pkg::ALU_XOR:  alu_result = alu_a ^ alu_b;
            core_pkg::ALU_SRL:  alu_result = alu_a >> alu_b[4:0];
            core_pkg::ALU_SRA:  alu_result = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            core_pkg::ALU_OR:   alu_result = alu_a | alu_b;
            default:            alu_result = alu_a & alu_b;
        endcase
    end

    // branch compare on the register operands
    always_comb begin
        case (dec.funct3)
            rv_isa_pkg::F3_BEQ:  taken = (rdata1 == rdata2);
            rv_isa_pkg::F3_BNE:  taken = (rdata1 != rdata2);
            rv_isa_pkg::F3_BLT:  taken = ($signed(rdata1) < $signed(rdata2));
            rv_isa_pkg::F3_BGE:  taken = ($signed(rdata1) >= $signed(rdata2));
            rv_isa_pkg::F3_BLTU: taken = (rdata1 < rdata2);
            rv_isa_pkg::F3_BGEU: taken = (rdata1 >= rdata2);
            default:             taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_en     = 1'b0;
        jump_target = alu_result;   // pc + imm for jal and branches
        case (dec.opcode)
            rv_isa_pkg::OP_JAL:    jump_en = 1'b1;
            rv_isa_pkg::OP_BRANCH: jump_en = taken;
            rv_isa_pkg::OP_JALR: begin
                jump_en     = 1'b1;
                jump_target = {alu_result[31:1], 1'b0};
            end
            default: ;
        endcase
    end

    assign ex = '{alu_result: alu_result, jump_en: jump_en, jump_target: jump_target};

endmodule

`default_nettype wire

// File: load_store_unit.sv
//**************************************************
// Load/store unit
//**************************************************
`default_nettype none

module load_store_unit (
    input  logic                clk,
    input  core_pkg::decode_t   dec,
    input  core_pkg::exec_t     ex,
    input  rv_isa_pkg::xlen_t   rdata2,
    input  logic                inst_valid,
    input  rv_isa_pkg::xlen_t   dmem_rdata,
    output core_pkg::dmem_req_t dmem_req,
    output rv_isa_pkg::xlen_t   load_data
);

    logic [3:0] wmask;

    always_comb begin
        wmask = 4'h0;
        if (dec.opcode == rv_isa_pkg::OP_STORE) begin
            case (dec.funct3)
                rv_isa_pkg::F3_SB: wmask = 4'h1;
                rv_isa_pkg::F3_SH: wmask = 4'h3;
                rv_isa_pkg::F3_SW: wmask = 4'hf;
                default:           wmask = 4'h0;   // unsupported width, no write
            endcase
        end
    end

    assign dmem_req = '{addr: ex.alu_result, wdata: rdata2, wmask: wmask,
                        we: inst_valid && (wmask != 4'h0)};

    // read data arrives aligned to addr
    always_comb begin
        case (dec.funct3)
            rv_isa_pkg::F3_LB:  load_data = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};
            rv_isa_pkg::F3_LH:  load_data = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};
            rv_isa_pkg::F3_LW:  load_data = dmem_rdata;
            rv_isa_pkg::F3_LBU: load_data = {24'b0, dmem_rdata[7:0]};
            rv_isa_pkg::F3_LHU: load_data = {16'b0, dmem_rdata[15:0]};
            default:            load_data = '0;
        endcase
    end

    // store strobe carries lanes and never repeats on the next cycle
    a_store_strobe: assert property (@(posedge clk)
        dmem_req.we |-> (dmem_req.wmask != 4'h0) ##1 !dmem_req.we);

endmodule

`default_nettype wire

// File: writeback_unit.sv
//**************************************************
// Write-back and retire
//**************************************************
`default_nettype none

module writeback_unit (
    input  core_pkg::decode_t dec,
    input  core_pkg::exec_t   ex,
    input  rv_isa_pkg::xlen_t load_data,
    input  rv_isa_pkg::xlen_t pc,
    input  rv_isa_pkg::xlen_t snpc,
    input  rv_isa_pkg::xlen_t next_pc,
    input  logic              inst_valid,
    output logic              rf_we,
    output rv_isa_pkg::xlen_t rf_wdata,
    output logic              retire_valid,
    output core_pkg::retire_t retire
);

    always_comb begin
        rf_we    = 1'b0;
        rf_wdata = '0;
        case (dec.opcode)
            rv_isa_pkg::OP_JAL,
            rv_isa_pkg::OP_JALR: begin
                rf_we    = 1'b1;
                rf_wdata = snpc;   // link address
            end
            rv_isa_pkg::OP_LOAD: begin
                rf_we    = 1'b1;
                rf_wdata = load_data;
            end
            rv_isa_pkg::OP_REG,
            rv_isa_pkg::OP_IMM,
            rv_isa_pkg::OP_LUI,
            rv_isa_pkg::OP_AUIPC: begin
                rf_we    = 1'b1;
                rf_wdata = ex.alu_result;
            end
            default: ;  // branch, store, unknown
        endcase
    end

    assign retire_valid = inst_valid;

    // trace shows the architectural write only, x0 targets report none
    assign retire = '{pc: pc, next_pc: next_pc, rd: dec.rd, wdata: rf_wdata,
                      we: rf_we && (dec.rd != '0)};

endmodule

`default_nettype wire

// File: core_top.sv
//**************************************************
// RV32I core top level
//**************************************************
`default_nettype none

module core_top #(
    parameter rv_isa_pkg::xlen_t RESET_PC = 32'h8000_0000
) (
    input  logic                clk,
    input  logic                reset,
    output rv_isa_pkg::xlen_t   imem_addr,
    input  rv_isa_pkg::xlen_t   imem_data,
    output core_pkg::dmem_req_t dmem_req,
    input  rv_isa_pkg::xlen_t   dmem_rdata,
    output logic                retire_valid,
    output core_pkg::retire_t   retire
);

    rv_isa_pkg::xlen_t snpc;
    rv_isa_pkg::xlen_t next_pc;
    rv_isa_pkg::xlen_t rdata1;
    rv_isa_pkg::xlen_t rdata2;
    rv_isa_pkg::xlen_t load_data;
    rv_isa_pkg::xlen_t rf_wdata;
    logic              inst_valid;
    logic              rf_we;
    core_pkg::decode_t dec;
    core_pkg::exec_t   ex;

    // imem_addr is the pc itself
    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .reset(reset), .jump_en(ex.jump_en), .jump_target(ex.jump_target),
        .pc(imem_addr), .snpc(snpc), .next_pc(next_pc), .inst_valid(inst_valid)
    );

    decode_unit u_decode (.inst(imem_data), .dec(dec));

    reg_file u_regs (
        .clk(clk), .reset(reset), .we(rf_we), .inst_valid(inst_valid),
        .waddr(dec.rd), .wdata(rf_wdata), .raddr1(dec.rs1), .raddr2(dec.rs2),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    execute_unit u_exec (
        .dec(dec), .pc(imem_addr), .rdata1(rdata1), .rdata2(rdata2), .ex(ex)
    );

    load_store_unit u_lsu (
        .clk(clk), .dec(dec), .ex(ex), .rdata2(rdata2), .inst_valid(inst_valid),
        .dmem_rdata(dmem_rdata), .dmem_req(dmem_req), .load_data(load_data)
    );

    writeback_unit u_wb (
        .dec(dec), .ex(ex), .load_data(load_data), .pc(imem_addr), .snpc(snpc),
        .next_pc(next_pc), .inst_valid(inst_valid), .rf_we(rf_we), .rf_wdata(rf_wdata),
        .retire_valid(retire_valid), .retire(retire)
    );

endmodule

`default_nettype wire

// File: tb_core.sv
//**************************************************
// RV32I core testbench
//**************************************************
`default_nettype none

module tb_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam rv_isa_pkg::xlen_t RESET_PC = 32'h0000_2000;

    logic                clk;
    logic                reset;
    rv_isa_pkg::xlen_t   imem_addr;
    rv_isa_pkg::xlen_t   imem_data;
    core_pkg::dmem_req_t dmem_req;
    rv_isa_pkg::xlen_t   dmem_rdata;
    logic                retire_valid;
    core_pkg::retire_t   retire;

    rv_isa_pkg::xlen_t imem [256];
    rv_isa_pkg::xlen_t dmem [256];      // data words indexed by addr[9:2]
    rv_isa_pkg::xlen_t ref_mem [256];
    rv_isa_pkg::xlen_t ref_regs [32];
    rv_isa_pkg::xlen_t ref_pc;
    rv_isa_pkg::xlen_t prog [$];
    logic running;
    logic exp_valid;                    // strobe phase the checker expects
    int   errors;
    int   ntests;
    int   nfailed;

    core_top #(.RESET_PC(RESET_PC)) UUT (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .retire_valid(retire_valid),
        .retire(retire)
    );

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (dmem_req.we && dmem_req.wmask[i]) begin
                dmem[dmem_req.addr[9:2]][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
            end
        end
    end

    // instruction encoders
    function automatic rv_isa_pkg::xlen_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
    endfunction

    function automatic rv_isa_pkg::xlen_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_isa_pkg::xlen_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::OP_STORE};
    endfunction

    function automatic rv_isa_pkg::xlen_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OP_BRANCH};
    endfunction

    function automatic rv_isa_pkg::xlen_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OP_JAL};
    endfunction

    function automatic rv_isa_pkg::xlen_t fill_word(input int i);
        return {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'hc3};
    endfunction

    function automatic rv_isa_pkg::xlen_t alu_ref(input logic [2:0] f3, input logic alt,
            input logic is_reg, input rv_isa_pkg::xlen_t x, input rv_isa_pkg::xlen_t y);
        case (f3)
            3'b000:  return (is_reg && alt) ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  return (x < y) ? 32'd1 : 32'd0;
            3'b100:  return x ^ y;
            3'b101:  return alt ? rv_isa_pkg::xlen_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    // one architectural step from ref_pc, ref_regs and ref_mem
    function automatic void iss_step(input rv_isa_pkg::xlen_t pc, input rv_isa_pkg::xlen_t inst,
            output core_pkg::retire_t r, output core_pkg::dmem_req_t st);
        logic [6:0] op;
        logic [2:0] f3;
        logic alt;
        logic wr;
        logic tk;
        rv_isa_pkg::xlen_t a, b, ii, si, bi, ji, npc, val, w;
        op  = inst[6:0];
        f3  = inst[14:12];
        alt = (inst[31:25] == 7'b0100000);
        a   = ref_regs[inst[19:15]];
        b   = ref_regs[inst[24:20]];
        ii  = {{20{inst[31]}}, inst[31:20]};
        si  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        bi  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        ji  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        npc = pc + 4;
        val = '0;
        wr  = 1'b0;
        tk  = 1'b0;
        st  = '0;
        case (op)
            rv_isa_pkg::OP_LUI:   {wr, val} = {1'b1, inst[31:12], 12'b0};
            rv_isa_pkg::OP_AUIPC: {wr, val} = {1'b1, pc + {inst[31:12], 12'b0}};
            rv_isa_pkg::OP_JAL: begin
                {wr, val} = {1'b1, pc + 32'd4};
                npc = pc + ji;
            end
            rv_isa_pkg::OP_JALR: begin
                {wr, val} = {1'b1, pc + 32'd4};
                npc = (a + ii) & ~32'd1;
            end
            rv_isa_pkg::OP_BRANCH: begin
                case (f3)
                    3'b000: tk = (a == b);
                    3'b001: tk = (a != b);
                    3'b100: tk = ($signed(a) < $signed(b));
                    3'b101: tk = ($signed(a) >= $signed(b));
                    3'b110: tk = (a < b);
                    3'b111: tk = (a >= b);
                    default: tk = 1'b0;
                endcase
                if (tk) npc = pc + bi;
            end
            rv_isa_pkg::OP_LOAD: begin
                w  = ref_mem[(a + ii) >> 2 & 32'hff];
                wr = 1'b1;
                case (f3)
                    3'b000: val = {{24{w[7]}}, w[7:0]};
                    3'b001: val = {{16{w[15]}}, w[15:0]};
                    3'b010: val = w;
                    3'b100: val = {24'b0, w[7:0]};
                    3'b101: val = {16'b0, w[15:0]};
                    default: val = '0;
                endcase
            end
            rv_isa_pkg::OP_STORE: begin
                st.addr  = a + si;
                st.wdata = b;
                st.wmask = (f3 == 3'b000) ? 4'h1 : (f3 == 3'b001) ? 4'h3 :
                           (f3 == 3'b010) ? 4'hf : 4'h0;
                st.we    = (st.wmask != 4'h0);
            end
            rv_isa_pkg::OP_IMM: {wr, val} = {1'b1, alu_ref(f3, alt, 1'b0, a, ii)};
            rv_isa_pkg::OP_REG: {wr, val} = {1'b1, alu_ref(f3, alt, 1'b1, a, b)};
            default: ;
        endcase
        r = '{pc: pc, next_pc: npc, rd: inst[11:7], wdata: val, we: wr && inst[11:7] != 5'd0};
    endfunction

    task automatic compare_field(input string name, input rv_isa_pkg::xlen_t exp,
            input rv_isa_pkg::xlen_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_retire(input core_pkg::retire_t act, input core_pkg::retire_t exp);
        compare_field("retire.pc", exp.pc, act.pc);
        compare_field("retire.next_pc", exp.next_pc, act.next_pc);
        compare_field("retire.rd", 32'(exp.rd), 32'(act.rd));
        compare_field("retire.wdata", exp.wdata, act.wdata);
        compare_field("retire.we", 32'(exp.we), 32'(act.we));
    endtask

    task automatic check_store(input core_pkg::dmem_req_t act, input core_pkg::dmem_req_t exp);
        compare_field("dmem_req.we", 32'(exp.we), 32'(act.we));
        compare_field("dmem_req.addr", exp.addr, act.addr);
        compare_field("dmem_req.wdata", exp.wdata, act.wdata);
        compare_field("dmem_req.wmask", 32'(exp.wmask), 32'(act.wmask));
    endtask

    // checks each retirement against the ISS at mid-cycle
    always @(negedge clk) begin
        core_pkg::retire_t   exp_ret;
        core_pkg::dmem_req_t exp_st;
        if (running) begin
            compare_field("retire_valid", 32'(exp_valid), 32'(retire_valid));
            if (retire_valid === 1'b1) begin
                compare_field("imem_addr", ref_pc, imem_addr);
                iss_step(ref_pc, imem[ref_pc[9:2]], exp_ret, exp_st);
                check_retire(retire, exp_ret);
                if (exp_st.we || dmem_req.we) check_store(dmem_req, exp_st);
                if (exp_ret.we) ref_regs[exp_ret.rd] = exp_ret.wdata;
                for (int i = 0; i < 4; i++) begin
                    if (exp_st.we && exp_st.wmask[i]) begin
                        ref_mem[exp_st.addr[9:2]][8*i +: 8] = exp_st.wdata[8*i +: 8];
                    end
                end
                ref_pc = exp_ret.next_pc;
            end else begin
                compare_field("dmem_req.we", 32'd0, 32'(dmem_req.we));
            end
            exp_valid = ~exp_valid;
        end
    end

    task automatic emit(input rv_isa_pkg::xlen_t inst);
        prog.push_back(inst);
    endtask

    task automatic emit_const(input logic [4:0] rd, input rv_isa_pkg::xlen_t v);
        emit({v[31:12] + 20'(v[11]), rd, rv_isa_pkg::OP_LUI});
        emit(enc_i(v[11:0], rd, 3'b000, rd, rv_isa_pkg::OP_IMM));
    endtask

    // reset the core and run prog until the ISS reaches its closing self loop
    task automatic run_program(input string name);
        rv_isa_pkg::xlen_t end_pc;
        int limit;
        int n;
        int errs_before;
        errs_before = errors;
        emit(enc_j(21'd0, 5'd0));
        end_pc = RESET_PC + 32'(4 * (prog.size() - 1));
        limit  = 4 * prog.size() + 20;
        @(negedge clk);
        reset = 1'b1;
        @(posedge clk);
        running = 1'b0;
        for (int i = 0; i < 256; i++) imem[i] = (i < prog.size()) ? prog[i] : prog[$];
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        ref_pc = RESET_PC;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            compare_field("retire_valid", 32'd0, 32'(retire_valid));
            compare_field("dmem_req.we", 32'd0, 32'(dmem_req.we));
        end
        reset = 1'b0;
        @(posedge clk);
        exp_valid = 1'b1;       // first retirement in the cycle after this edge
        running   = 1'b1;
        for (n = 0; n < limit && ref_pc != end_pc; n++) @(posedge clk);
        if (ref_pc != end_pc) begin
            $display("timeout: %s did not reach its last instruction", name);
            $display("tests failed");
            $finish;
        end else begin
            ntests++;
            if (errors != errs_before) nfailed++;
            $display("test %0d %s: %s", ntests, name, (errors == errs_before) ? "ok" : "FAIL");
            prog.delete();
        end
    endtask

    initial begin
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [2:0]  conds [6];
        reset   = 1'b1;
        running = 1'b0;
        errors  = 0;
        ntests  = 0;
        nfailed = 0;
        conds   = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        void'($urandom(32'h6f08a14a));
        for (int i = 0; i < 256; i++) begin
            imem[i]    = enc_j(21'd0, 5'd0);
            dmem[i]    = fill_word(i);
            ref_mem[i] = fill_word(i);
        end

        emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, rv_isa_pkg::OP_IMM));
        emit(enc_i(12'd3, 5'd1, 3'b000, 5'd0, rv_isa_pkg::OP_IMM));   // x0 target
        emit(enc_r(7'd0, 5'd1, 5'd0, 3'b000, 5'd2));
        run_program("reset and retire timing");

        for (int r = 1; r < 8; r++) emit_const(5'(r), $urandom());
        emit(enc_r(7'b0100000, 5'd3, 5'd2, 3'b000, 5'd1));   // sub
        emit(enc_r(7'b0100000, 5'd6, 5'd5, 3'b101, 5'd4));   // sra
        emit(enc_r(7'd0, 5'd2, 5'd1, 3'b010, 5'd7));
        emit(enc_r(7'd0, 5'd2, 5'd1, 3'b011, 5'd6));
        repeat (24) begin
            rd  = 5'($urandom_range(7, 0));
            rs1 = 5'($urandom_range(7, 0));
            rs2 = 5'($urandom_range(7, 0));
            f3  = 3'($urandom_range(7, 0));
            f7  = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1, 0)) ? 7'h20 : 7'h00;
            imm = 12'($urandom());
            if (f3 == 3'b001 || f3 == 3'b101) imm = {(f3 == 3'b101) ? f7 : 7'h00, imm[4:0]};
            if ($urandom_range(1, 0)) emit(enc_r(f7, rs2, rs1, f3, rd));
            else emit(enc_i(imm, rs1, f3, rd, rv_isa_pkg::OP_IMM));
        end
        emit(enc_r(7'd0, 5'd0, 5'd0, 3'b110, 5'd8));    // reads x0 back
        run_program("random arithmetic");

        repeat (4) begin
            emit({20'($urandom()), 5'($urandom_range(7, 1)), rv_isa_pkg::OP_LUI});
            emit({20'($urandom()), 5'($urandom_range(7, 1)), rv_isa_pkg::OP_AUIPC});
        end
        run_program("lui and auipc");

        emit({20'h1, 5'd1, rv_isa_pkg::OP_LUI});       // x1 = 0x1000
        emit_const(5'd2, $urandom());
        emit_const(5'd3, $urandom() | 32'h8080);
        emit_const(5'd4, $urandom() | 32'h80);
        emit(enc_s(12'd0, 5'd2, 5'd1, 3'b010));
        emit(enc_s(12'd4, 5'd3, 5'd1, 3'b001));
        emit(enc_s(12'd8, 5'd4, 5'd1, 3'b000));
        emit(enc_s(12'hffc, 5'd2, 5'd1, 3'b000));
        emit(enc_i(12'd0, 5'd1, 3'b010, 5'd5, rv_isa_pkg::OP_LOAD));
        emit(enc_i(12'd4, 5'd1, 3'b001, 5'd6, rv_isa_pkg::OP_LOAD));
        emit(enc_i(12'd4, 5'd1, 3'b101, 5'd7, rv_isa_pkg::OP_LOAD));
        emit(enc_i(12'd8, 5'd1, 3'b000, 5'd8, rv_isa_pkg::OP_LOAD));
        emit(enc_i(12'd8, 5'd1, 3'b100, 5'd9, rv_isa_pkg::OP_LOAD));
        emit(enc_i(12'd12, 5'd1, 3'b010, 5'd10, rv_isa_pkg::OP_LOAD));
        emit(enc_i(12'hffc, 5'd1, 3'b000, 5'd11, rv_isa_pkg::OP_LOAD));
        emit(enc_i(12'd16, 5'd1, 3'b001, 5'd12, rv_isa_pkg::OP_LOAD));
        run_program("loads and stores");

        emit_const(5'd1, $urandom());
        emit_const(5'd2, $urandom());
        emit(enc_i(12'd0, 5'd1, 3'b000, 5'd3, rv_isa_pkg::OP_IMM));    // x3 equals x1
        emit_const(5'd4, $urandom() | 32'h8000_0000);
        emit_const(5'd5, $urandom() & 32'h7fff_ffff);
        foreach (conds[c]) begin
            emit(enc_b(13'd8, 5'd2, 5'd1, conds[c]));
            emit(enc_i(12'd1, 5'd10, 3'b000, 5'd10, rv_isa_pkg::OP_IMM));
            emit(enc_b(13'd8, 5'd3, 5'd1, conds[c]));
            emit(enc_i(12'd1, 5'd10, 3'b000, 5'd10, rv_isa_pkg::OP_IMM));
            emit(enc_b(13'd8, 5'd5, 5'd4, conds[c]));
            emit(enc_i(12'd1, 5'd10, 3'b000, 5'd10, rv_isa_pkg::OP_IMM));
            emit(enc_b(13'd8, 5'd4, 5'd5, conds[c]));
            emit(enc_i(12'd1, 5'd10, 3'b000, 5'd10, rv_isa_pkg::OP_IMM));
        end
        run_program("branches");

        emit(enc_j(21'd8, 5'd1));
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd5, rv_isa_pkg::OP_IMM));   // skipped
        emit({20'd0, 5'd6, rv_isa_pkg::OP_AUIPC});
        emit(enc_i(12'd13, 5'd6, 3'b000, 5'd7, rv_isa_pkg::OP_JALR));  // odd target
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd5, rv_isa_pkg::OP_IMM));   // skipped
        emit(enc_i(12'd2, 5'd0, 3'b000, 5'd8, rv_isa_pkg::OP_IMM));
        run_program("jal and jalr");

        $display("%0d of %0d tests ok, %0d errors", ntests - nfailed, ntests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rv_isa_pkg.sv
core_pkg.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
execute_unit.sv
load_store_unit.sv
writeback_unit.sv
core_top.sv
tb_core.sv
